/* logic/lvl_pkg.sv */
/*
 * lvl_pkg: shared widths, types and register map of the level-state stack
 * used by the bus decoder, the level cells and the backtrack selector
 */
package lvl_pkg;

    localparam int WIDTH_BIN = 10;  // literal bin id
    localparam int WIDTH_LVL = 16;  // decision level number

    typedef logic [WIDTH_BIN-1:0] bin_t;
    typedef logic [WIDTH_LVL-1:0] lvl_t;
    typedef logic [31:0]          wb_data_t;

    // search chain flag, passed from the top cell downwards
    typedef enum logic [1:0] {
        FIND_NONE = 2'd0,  // nothing found above
        FIND_HIT  = 2'd1,  // this cell is the hit
        FIND_PASS = 2'd2   // hit already found further up
    } find_flag_e;

    // saved state of one level
    typedef struct packed {
        bin_t dcd_bin;
        logic has_bkt;
    } lvl_states_t;

    // command broadcast to every cell
    typedef struct packed {
        logic        decide;
        logic        load;
        logic        apply_bkt;
        lvl_t        sel_lvl;
        bin_t        bin;
        lvl_states_t states;
        lvl_t        max_lvl;
    } lvl_cmd_t;

    typedef struct packed {
        logic found;
        lvl_t hit_lvl;
        bin_t hit_bin;
    } bkt_result_t;

    // word addresses of the bus registers
    localparam logic [2:0] ADDR_DECIDE   = 3'd0;
    localparam logic [2:0] ADDR_LOAD     = 3'd1;
    localparam logic [2:0] ADDR_MAX_LVL  = 3'd2;
    localparam logic [2:0] ADDR_BKT      = 3'd3;
    localparam logic [2:0] ADDR_RESULT   = 3'd4;
    localparam logic [2:0] ADDR_RD_SEL   = 3'd5;
    localparam logic [2:0] ADDR_RD_STATE = 3'd6;

endpackage

/* logic/lvl_wb_ctrl.sv */
/*
 * Wishbone classic slave of the level stack
 * turns bus writes into per-level commands, holds max_lvl and the
 * read select, and serves result and level state reads
 */
module lvl_wb_ctrl #(
    parameter int NUM_LVLS = 8
) (
    input  logic                  clk,
    input  logic                  rst,

    // wishbone classic slave
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [2:0]            wb_adr_i,
    input  lvl_pkg::wb_data_t     wb_dat_i,
    output lvl_pkg::wb_data_t     wb_dat_o,
    output logic                  wb_ack_o,

    // stack side
    input  lvl_pkg::lvl_states_t  cell_states_i [NUM_LVLS],
    input  lvl_pkg::bkt_result_t  result_i,
    output lvl_pkg::lvl_cmd_t     cmd_o
);

    import lvl_pkg::*;

    localparam int   IDX_W      = (NUM_LVLS > 1) ? $clog2(NUM_LVLS) : 1;
    localparam lvl_t NUM_LVLS_L = lvl_t'(NUM_LVLS);

    typedef enum logic {
        BUS_IDLE,
        BUS_ACK
    } bus_state_e;

    bus_state_e state_q;
    logic       req;        // transfer request seen on the bus
    logic       accept;     // request taken this cycle
    logic       wr_ack;     // write in its ack cycle
    lvl_t       max_lvl_q;
    lvl_t       rd_sel_q;
    wb_data_t   rd_data;

    assign req      = wb_cyc_i & wb_stb_i;
    assign accept   = req & (state_q == BUS_IDLE);
    assign wb_ack_o = (state_q == BUS_ACK);

    // host holds its signals through the ack cycle, so decode straight off the bus
    assign wr_ack = wb_ack_o & req & wb_we_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= BUS_IDLE;
        end else begin
            case (state_q)
                BUS_IDLE: if (req) state_q <= BUS_ACK;
                BUS_ACK:  state_q <= BUS_IDLE;   // single cycle ack
                default:  state_q <= BUS_IDLE;
            endcase
        end
    end

    // max level and read select registers
    always_ff @(posedge clk) begin
        if (!rst) begin
            max_lvl_q <= '0;
            rd_sel_q  <= '0;
        end else if (wr_ack) begin
            if (wb_adr_i == ADDR_MAX_LVL) begin
                max_lvl_q <= wb_dat_i[15:0];
            end
            if (wb_adr_i == ADDR_RD_SEL) begin
                rd_sel_q <= wb_dat_i[15:0];
            end
        end
    end

    // command broadcast whose strobes live only in the ack cycle
    always_comb begin
        cmd_o.decide         = wr_ack & (wb_adr_i == ADDR_DECIDE);
        cmd_o.load           = wr_ack & (wb_adr_i == ADDR_LOAD);
        cmd_o.apply_bkt      = wr_ack & (wb_adr_i == ADDR_BKT);
        cmd_o.sel_lvl        = wb_dat_i[31:16];
        cmd_o.bin            = wb_dat_i[9:0];
        cmd_o.states.dcd_bin = wb_dat_i[9:0];
        cmd_o.states.has_bkt = wb_dat_i[10];
        cmd_o.max_lvl        = max_lvl_q;
    end

    // read mux
    always_comb begin
        rd_data = '0;
        case (wb_adr_i)
            ADDR_RESULT: begin
                rd_data[31]    = result_i.found;
                rd_data[25:10] = result_i.hit_lvl;
                rd_data[9:0]   = result_i.hit_bin;
            end
            ADDR_RD_STATE: begin
                if (rd_sel_q < NUM_LVLS_L) begin
                    rd_data[10:0] = cell_states_i[rd_sel_q[IDX_W-1:0]];
                end
            end
            default: rd_data = '0;
        endcase
    end

    // read data is sampled when the request is taken and held through ack
    always_ff @(posedge clk) begin
        if (accept && !wb_we_i) begin
            wb_dat_o <= rd_data;
        end
    end

endmodule

/* logic/lvl_cell.sv */
/*
 * lvl_cell: state of one decision level
 * holds bin, level and backtrack flag and takes one step of the search chain
 */
module lvl_cell #(
    parameter int LVL_IDX = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  lvl_pkg::lvl_cmd_t     cmd_i,
    input  lvl_pkg::find_flag_e   flag_i,
    output lvl_pkg::find_flag_e   flag_o,
    output logic                  hit_o,
    output lvl_pkg::bin_t         bkt_bin_o,
    output lvl_pkg::lvl_states_t  states_o
);

    import lvl_pkg::*;

    bin_t dcd_bin_q;
    logic has_bkt_q;
    lvl_t var_lvl_q;
    logic sel;          // decide or load is aimed here

    assign sel = (cmd_i.sel_lvl == lvl_t'(LVL_IDX));

    // chain step, pass once something above has hit
    always_comb begin
        if (flag_i != FIND_NONE) begin
            flag_o = FIND_PASS;
        end else if (cmd_i.max_lvl >= var_lvl_q && !has_bkt_q) begin
            flag_o = FIND_HIT;
        end else begin
            flag_o = FIND_NONE;
        end
    end

    assign hit_o    = (flag_o == FIND_HIT);
    assign states_o = '{dcd_bin: dcd_bin_q, has_bkt: has_bkt_q};

    always_ff @(posedge clk) begin
        if (!rst) begin
            dcd_bin_q <= '0;
            var_lvl_q <= '0;
        end else if (cmd_i.load && sel) begin
            dcd_bin_q <= cmd_i.states.dcd_bin;
            var_lvl_q <= cmd_i.sel_lvl;
        end else if (cmd_i.decide && sel) begin
            dcd_bin_q <= cmd_i.bin;
            var_lvl_q <= cmd_i.sel_lvl;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            has_bkt_q <= 1'b0;
        end else if (cmd_i.load && sel) begin
            has_bkt_q <= cmd_i.states.has_bkt;
        end else if (cmd_i.apply_bkt) begin
            case (flag_o)
                FIND_NONE: has_bkt_q <= 1'b0;   // above the hit, reopen
                FIND_HIT:  has_bkt_q <= 1'b1;   // hit level flips
                default:   has_bkt_q <= has_bkt_q;
            endcase
        end
    end

    // bin only shows up for the hit cell
    always_ff @(posedge clk) begin
        if (!rst) begin
            bkt_bin_o <= '0;
        end else begin
            bkt_bin_o <= hit_o ? dcd_bin_q : '0;
        end
    end

endmodule

/* logic/lvl_bkt_select.sv */
/*
 * lvl_bkt_select: reduces the search chain outputs to one registered
 * result with found flag, hit level and hit bin
 */
module lvl_bkt_select #(
    parameter int NUM_LVLS = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NUM_LVLS-1:0]   hit_i,
    input  lvl_pkg::bin_t         bkt_bin_i [NUM_LVLS],
    output lvl_pkg::bkt_result_t  result_o
);

    import lvl_pkg::*;

    logic [NUM_LVLS-1:0] hit_q;     // lines up with the registered bins
    lvl_t                hit_lvl;
    bin_t                hit_bin;

    always_ff @(posedge clk) begin
        if (!rst) begin
            hit_q <= '0;
        end else begin
            hit_q <= hit_i;
        end
    end

    // one-hot to index
    always_comb begin
        hit_lvl = '0;
        for (int i = 0; i < NUM_LVLS; i++) begin
            if (hit_q[i]) begin
                hit_lvl = lvl_t'(i);
            end
        end
    end

    // non-hit cells hold zero, so an OR picks the hit bin
    always_comb begin
        hit_bin = '0;
        for (int i = 0; i < NUM_LVLS; i++) begin
            hit_bin = hit_bin | bkt_bin_i[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            result_o <= '0;
        end else begin
            result_o.found   <= |hit_q;
            result_o.hit_lvl <= hit_lvl;
            result_o.hit_bin <= hit_bin;
        end
    end

endmodule

/* logic/lvl_stack_top.sv */
/*
 * lvl_stack_top: level-state stack of the decision engine
 * bus decoder, chain of level cells and backtrack selector
 */
module lvl_stack_top #(
    parameter int NUM_LVLS = 8
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  logic [2:0]         wb_adr_i,
    input  lvl_pkg::wb_data_t  wb_dat_i,
    output lvl_pkg::wb_data_t  wb_dat_o,
    output logic               wb_ack_o
);

    import lvl_pkg::*;

    lvl_cmd_t            cmd;
    bkt_result_t         result;
    lvl_states_t         cell_states [NUM_LVLS];
    bin_t                bkt_bin     [NUM_LVLS];
    logic [NUM_LVLS-1:0] hit_vec;
    find_flag_e          flag_chain  [NUM_LVLS+1];  // entry i is the output of cell i

    assign flag_chain[NUM_LVLS] = FIND_NONE;        // nothing above the top cell

    lvl_wb_ctrl #(
        .NUM_LVLS (NUM_LVLS)
    ) u_wb_ctrl (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .cell_states_i (cell_states),
        .result_i      (result),
        .cmd_o         (cmd)
    );

    for (genvar i = 0; i < NUM_LVLS; i++) begin : g_lvl
        lvl_cell #(
            .LVL_IDX (i)
        ) u_cell (
            .clk       (clk),
            .rst       (rst),
            .cmd_i     (cmd),
            .flag_i    (flag_chain[i+1]),
            .flag_o    (flag_chain[i]),
            .hit_o     (hit_vec[i]),
            .bkt_bin_o (bkt_bin[i]),
            .states_o  (cell_states[i])
        );
    end

    lvl_bkt_select #(
        .NUM_LVLS (NUM_LVLS)
    ) u_bkt_select (
        .clk       (clk),
        .rst       (rst),
        .hit_i     (hit_vec),
        .bkt_bin_i (bkt_bin),
        .result_o  (result)
    );

endmodule

/* sim/lvl_stack_asserts.sv */
/*
 * lvl_stack_asserts: Wishbone ack protocol and one-hot search hit checks,
 * bound into the stack top level
 */
module lvl_stack_asserts #(
    parameter int NUM_LVLS = 8
) (
    input logic                clk,
    input logic                rst,
    input logic                wb_cyc_i,
    input logic                wb_stb_i,
    input logic                wb_ack_i,
    input logic [NUM_LVLS-1:0] hit_vec_i
);

    int fail_cnt = 0;   // failed assertion count

    // ack is a single cycle pulse
    a_ack_single: assert property (@(posedge clk) disable iff (!rst)
        wb_ack_i |=> !wb_ack_i)
        else begin
            $error("wb ack held for more than one cycle");
            fail_cnt = fail_cnt + 1;
        end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else begin
            $error("wb ack outside an active cyc and stb");
            fail_cnt = fail_cnt + 1;
        end

    // at most one cell may claim the hit
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(hit_vec_i))
        else begin
            $error("more than one level reports a search hit");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind lvl_stack_top lvl_stack_asserts #(
    .NUM_LVLS (NUM_LVLS)
) u_asserts (
    .clk       (clk),
    .rst       (rst),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_ack_i  (wb_ack_o),
    .hit_vec_i (hit_vec)
);

/* sim/lvl_stack_tb.sv */
/*
 * lvl_stack_tb: table-driven testbench of the level-state stack
 * drives the Wishbone port and checks against a model of the level cells
 */
module lvl_stack_tb;

    import lvl_pkg::*;

    localparam int NUM_LVLS  = 8;
    localparam int MAX_ROWS  = 128;
    localparam int IDLE_GAP  = 3;   // settle time before a RESULT read
    localparam int OP_WRITE  = 0;
    localparam int OP_STATE  = 1;   // select a level, then read its state
    localparam int OP_RESULT = 2;

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [2:0] wb_adr;
    wb_data_t   wb_dat_w;
    wb_data_t   wb_dat_r;
    logic       wb_ack;

    // test table
    string      row_name [MAX_ROWS];
    int         row_op   [MAX_ROWS];
    logic [2:0] row_addr [MAX_ROWS];
    wb_data_t   row_data [MAX_ROWS];
    wb_data_t   row_exp  [MAX_ROWS];
    int         n_rows;

    // reference model of the cells
    bin_t       m_bin  [NUM_LVLS];
    logic       m_flag [NUM_LVLS];
    lvl_t       m_lvl  [NUM_LVLS];
    lvl_t       m_max;

    logic [31:0] rng_state;
    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    int          cycle_limit;

    lvl_stack_top #(
        .NUM_LVLS (NUM_LVLS)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic bin_t rand_bin();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // LCG step
        return rng_state[25:16];
    endfunction

    // highest level at or below max with a clear flag
    function automatic bkt_result_t model_search();
        bkt_result_t r;
        r = '0;
        for (int i = NUM_LVLS - 1; i >= 0; i--) begin
            if (!r.found && m_max >= m_lvl[i] && !m_flag[i]) begin
                r.found   = 1'b1;
                r.hit_lvl = lvl_t'(i);
                r.hit_bin = m_bin[i];
            end
        end
        return r;
    endfunction

    function automatic void model_backtrack();
        logic seen;
        seen = 1'b0;
        for (int i = NUM_LVLS - 1; i >= 0; i--) begin
            if (!seen) begin
                if (m_max >= m_lvl[i] && !m_flag[i]) begin
                    m_flag[i] = 1'b1;   // the hit
                    seen      = 1'b1;
                end else begin
                    m_flag[i] = 1'b0;   // above the hit
                end
            end
        end
    endfunction

    task automatic push_row(input string name, input int op, input logic [2:0] addr,
                            input wb_data_t data, input wb_data_t exp);
        row_name[n_rows] = name;
        row_op[n_rows]   = op;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_exp[n_rows]  = exp;
        n_rows++;
    endtask

    task automatic decide_row(input int lvl, input bin_t bin);
        wb_data_t d;
        d        = '0;
        d[31:16] = lvl_t'(lvl);
        d[9:0]   = bin;
        m_bin[lvl] = bin;
        m_lvl[lvl] = lvl_t'(lvl);
        push_row($sformatf("decide_l%0d", lvl), OP_WRITE, ADDR_DECIDE, d, '0);
    endtask

    task automatic load_row(input int lvl, input logic flag, input bin_t bin);
        wb_data_t d;
        d        = '0;
        d[31:16] = lvl_t'(lvl);
        d[10]    = flag;
        d[9:0]   = bin;
        m_bin[lvl]  = bin;
        m_flag[lvl] = flag;
        m_lvl[lvl]  = lvl_t'(lvl);
        push_row($sformatf("load_l%0d", lvl), OP_WRITE, ADDR_LOAD, d, '0);
    endtask

    task automatic max_row(input int lvl);
        m_max = lvl_t'(lvl);
        push_row($sformatf("max_lvl_%0d", lvl), OP_WRITE, ADDR_MAX_LVL, wb_data_t'(lvl), '0);
    endtask

    task automatic bkt_row();
        model_backtrack();
        push_row("backtrack", OP_WRITE, ADDR_BKT, '0, '0);
    endtask

    task automatic state_rows(input string prefix);
        lvl_states_t s;
        wb_data_t    e;
        for (int i = 0; i < NUM_LVLS; i++) begin
            s.dcd_bin = m_bin[i];
            s.has_bkt = m_flag[i];
            e         = '0;
            e[10:0]   = s;
            push_row($sformatf("%s_l%0d", prefix, i), OP_STATE, ADDR_RD_SEL, wb_data_t'(i), e);
        end
    endtask

    task automatic result_row(input string name);
        wb_data_t e;
        e       = '0;
        e[26:0] = model_search();
        push_row(name, OP_RESULT, ADDR_RESULT, '0, e);
    endtask

    task automatic build_table();
        n_rows = 0;
        m_max  = '0;
        for (int i = 0; i < NUM_LVLS; i++) begin
            m_bin[i]  = '0;
            m_flag[i] = 1'b0;
            m_lvl[i]  = '0;
        end
        // fresh cells all sit at level 0 with clear flags, so the top index hits
        result_row("reset_result");
        state_rows("reset_state");
        for (int i = 0; i < NUM_LVLS; i++) begin
            decide_row(i, rand_bin());
        end
        state_rows("decide_state");
        max_row(7);
        result_row("max7_result");
        load_row(7, 1'b1, rand_bin());
        load_row(6, 1'b1, rand_bin());
        result_row("loaded_result");
        max_row(3);
        result_row("max3_result");
        load_row(0, 1'b1, rand_bin());  // no clear flag left at level 0
        max_row(0);
        result_row("max0_result");
        max_row(5);
        result_row("max5_result");
        bkt_row();
        state_rows("bkt_state");
        result_row("second_search");
        result_row("plain_read");
        state_rows("reread_state");
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_ack();
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
    endtask

    task automatic release_bus();
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
    endtask

    task automatic wb_write(input logic [2:0] addr, input wb_data_t data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        wait_ack();
        idle_cycles(1);     // hold through the ack edge
        release_bus();
    endtask

    task automatic wb_read(input logic [2:0] addr, output wb_data_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        wait_ack();
        data = wb_dat_r;
        idle_cycles(1);
        release_bus();
    endtask

    task automatic check_states(input string name, input lvl_states_t exp,
                                input lvl_states_t act);
        if (act === exp) begin
            pass_cnt++;
            $display("ok      %s: bin %h has_bkt %b", name, act.dcd_bin, act.has_bkt);
        end else begin
            fail_cnt++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_result(input string name, input bkt_result_t exp,
                                input bkt_result_t act);
        if (act === exp) begin
            pass_cnt++;
            $display("ok      %s: found %b level %0d bin %h", name, act.found,
                     act.hit_lvl, act.hit_bin);
        end else begin
            fail_cnt++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic apply_row(input int i);
        wb_data_t    rd;
        bkt_result_t got;
        case (row_op[i])
            OP_WRITE: begin
                wb_write(row_addr[i], row_data[i]);
                $display("done    %s: wrote %h to address %0d", row_name[i], row_data[i],
                         row_addr[i]);
            end
            OP_STATE: begin
                wb_write(ADDR_RD_SEL, row_data[i]);
                wb_read(ADDR_RD_STATE, rd);
                check_states(row_name[i], lvl_states_t'(row_exp[i][10:0]),
                             lvl_states_t'(rd[10:0]));
            end
            default: begin
                idle_cycles(IDLE_GAP);  // let the chain and selector settle
                wb_read(ADDR_RESULT, rd);
                got.found   = rd[31];
                got.hit_lvl = rd[25:10];
                got.hit_bin = rd[9:0];
                check_result(row_name[i], bkt_result_t'(row_exp[i][26:0]), got);
            end
        endcase
    endtask

    initial begin
        rst       = 1'b0;
        release_bus();
        pass_cnt  = 0;
        fail_cnt  = 0;
        cycle_cnt = 0;
        rng_state = 32'he6e9_8c7d;
        build_table();
        cycle_limit = n_rows * 20 + 100;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
        end
        idle_cycles(2);
        fail_cnt = fail_cnt + dut.u_asserts.fail_cnt;
        $display("summary: %0d checks passed, %0d failed (%0d from assertions)",
                 pass_cnt, fail_cnt, dut.u_asserts.fail_cnt);
        if (fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* lvl_stack.f */
logic/lvl_pkg.sv
logic/lvl_wb_ctrl.sv
logic/lvl_cell.sv
logic/lvl_bkt_select.sv
logic/lvl_stack_top.sv
sim/lvl_stack_asserts.sv
sim/lvl_stack_tb.sv

/* Bender.yml */
package:
  name: lvl_stack

sources:
  # design, package first
  - files:
      - logic/lvl_pkg.sv
      - logic/lvl_wb_ctrl.sv
      - logic/lvl_cell.sv
      - logic/lvl_bkt_select.sv
      - logic/lvl_stack_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/lvl_stack_asserts.sv
      - sim/lvl_stack_tb.sv
